/* include/pix_macros.svh */
`ifndef PIX_MACROS_SVH
`define PIX_MACROS_SVH

// ====================
// Image geometry
// ====================

// Words per image, one block holds one image (4 by 4 test image)
`define PIX_IMAGE_WORDS 16
`define PIX_BLOCKS 8

// Address is block number then word offset
`define PIX_OFFSET_W 4
`define PIX_BLOCK_W 3
`define PIX_ADDR_W 7

// Capture buffer between sensor and memory
`define PIX_BUF_DEPTH 4

`endif

/* source/pix_pkg.sv */
`include "pix_macros.svh"

package pix_pkg;

    // Raw sensor pixel and stored memory word
    typedef logic [11:0] pix_t;
    typedef logic [15:0] word_t;

    typedef logic [`PIX_BLOCK_W-1:0]  block_t;
    typedef logic [`PIX_OFFSET_W-1:0] offset_t;
    // Block number in the upper bits, offset below
    typedef logic [`PIX_ADDR_W-1:0]   addr_t;

    typedef enum logic {
        CMD_CAPTURE = 1'b0,
        CMD_READOUT = 1'b1
    } cmd_t;

    // ====================
    // State machines
    // ====================
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_RUN_CAPTURE,
        CTRL_RUN_READOUT,
        CTRL_FINISH
    } ctrl_state_t;

    typedef enum logic [2:0] {
        CAP_IDLE,
        CAP_WAIT_INVALID,
        CAP_WAIT_START,
        CAP_ACTIVE,
        CAP_FLUSH
    } cap_state_t;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_WAIT_REQ,
        RD_FETCH,
        RD_ACK_HOST,
        RD_DONE
    } rd_state_t;

endpackage

/* source/pix_frame_ram.sv */
`timescale 1ns/1ps

`include "pix_macros.svh"

module pix_frame_ram (
    input  logic           clk,
    input  logic           mem_en,
    input  logic           mem_we,
    input  pix_pkg::addr_t mem_addr,
    input  pix_pkg::word_t mem_wdata,
    output pix_pkg::word_t mem_rdata
);
    import pix_pkg::*;

    // All blocks back to back, block number in the upper address bits
    word_t mem_array [`PIX_BLOCKS * `PIX_IMAGE_WORDS];

    // Read data only changes on a read, so it holds across writes
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem_array[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem_array[mem_addr];
            end
        end
    end

endmodule

/* source/pix_mem_arbiter.sv */
`timescale 1ns/1ps

module pix_mem_arbiter (
    input  logic           clk,
    input  logic           rst_n,

    // Client 0, capture engine
    input  logic           m0_req,
    output logic           m0_ack,
    input  logic           m0_we,
    input  pix_pkg::addr_t m0_addr,
    input  pix_pkg::word_t m0_wdata,

    // Client 1, readout engine
    input  logic           m1_req,
    output logic           m1_ack,
    input  pix_pkg::addr_t m1_addr,
    output pix_pkg::word_t m1_rdata,

    // Frame memory
    output logic           mem_en,
    output logic           mem_we,
    output pix_pkg::addr_t mem_addr,
    output pix_pkg::word_t mem_wdata,
    input  pix_pkg::word_t mem_rdata
);
    logic busy;
    // Owner 0 is capture, 1 is readout
    logic owner;
    logic grant_m0;
    logic grant_m1;

    // Capture wins a tie since its buffer is finite
    assign grant_m0 = !busy && m0_req;
    assign grant_m1 = !busy && !m0_req && m1_req;

    assign m1_rdata = mem_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            owner  <= 1'b0;
            mem_en <= 1'b0;
            m0_ack <= 1'b0;
            m1_ack <= 1'b0;
        end else begin
            mem_en <= 1'b0;
            if (grant_m0 || grant_m1) begin
                busy   <= 1'b1;
                owner  <= grant_m1;
                mem_en <= 1'b1;
            end else if (mem_en) begin
                // Access done, read data is in the memory register now
                if (owner) begin
                    m1_ack <= 1'b1;
                end else begin
                    m0_ack <= 1'b1;
                end
            end else if (m0_ack && !m0_req) begin
                m0_ack <= 1'b0;
                busy   <= 1'b0;
            end else if (m1_ack && !m1_req) begin
                m1_ack <= 1'b0;
                busy   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_m0) begin
            mem_we    <= m0_we;
            mem_addr  <= m0_addr;
            mem_wdata <= m0_wdata;
        end else if (grant_m1) begin
            mem_we   <= 1'b0;
            mem_addr <= m1_addr;
        end
    end

    acks_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(m0_ack && m1_ack))
        else $error("Both memory clients acknowledged at once");

endmodule

/* source/pix_capture.sv */
`timescale 1ns/1ps

`include "pix_macros.svh"

module pix_capture (
    input  logic            clk,
    input  logic            rst_n,

    // Job port
    input  logic            cap_req,
    input  pix_pkg::block_t cap_block,
    output logic            cap_ack,

    // Sensor
    input  logic            pix_fv,
    input  logic            pix_lv,
    input  pix_pkg::pix_t   pix_d,

    // Memory client
    output logic            m0_req,
    input  logic            m0_ack,
    output logic            m0_we,
    output pix_pkg::addr_t  m0_addr,
    output pix_pkg::word_t  m0_wdata
);
    import pix_pkg::*;

    localparam int PTR_W = $clog2(`PIX_BUF_DEPTH);
    localparam int CNT_W = $clog2(`PIX_BUF_DEPTH + 1);

    cap_state_t       state;
    block_t           job_block;
    word_t            buffer [`PIX_BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] buf_count;
    // Pixels taken from the current frame
    logic [`PIX_OFFSET_W:0] taken;
    offset_t          wr_offset;
    logic             start;
    logic             in_frame;
    logic             push;
    logic             pop;
    logic             write_done;

    assign start      = (state == CAP_IDLE) && cap_req && !cap_ack;
    assign in_frame   = ((state == CAP_WAIT_START) || (state == CAP_ACTIVE)) && pix_fv;
    // Pixels past a full image are dropped
    assign push       = in_frame && pix_lv && (taken != `PIX_IMAGE_WORDS);
    // Next write only once the previous handshake has fully closed
    assign pop        = !m0_req && !m0_ack && (buf_count != '0);
    assign write_done = m0_req && m0_ack;
    assign m0_we      = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CAP_IDLE;
            cap_ack   <= 1'b0;
            m0_req    <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            buf_count <= '0;
            taken     <= '0;
            wr_offset <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                taken  <= taken + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                m0_req <= 1'b1;
            end
            if (write_done) begin
                m0_req    <= 1'b0;
                wr_offset <= wr_offset + 1'b1;
            end
            if (push && !pop) begin
                buf_count <= buf_count + 1'b1;
            end else if (pop && !push) begin
                buf_count <= buf_count - 1'b1;
            end

            case (state)
                CAP_IDLE: begin
                    if (cap_ack && !cap_req) begin
                        cap_ack <= 1'b0;
                    end else if (start) begin
                        taken     <= '0;
                        wr_offset <= '0;
                        state     <= CAP_WAIT_INVALID;
                    end
                end
                // Skip any frame already in progress
                CAP_WAIT_INVALID: if (!pix_fv) state <= CAP_WAIT_START;
                CAP_WAIT_START:   if (pix_fv) state <= CAP_ACTIVE;
                CAP_ACTIVE:       if (!pix_fv) state <= CAP_FLUSH;
                CAP_FLUSH: begin
                    if ((buf_count == '0) && !m0_req && !m0_ack) begin
                        cap_ack <= 1'b1;
                        state   <= CAP_IDLE;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            job_block <= cap_block;
        end
        if (push) begin
            buffer[wr_ptr] <= {4'b0000, pix_d};
        end
        if (pop) begin
            m0_addr  <= {job_block, wr_offset};
            m0_wdata <= buffer[rd_ptr];
        end
    end

    // Sensor rate must stay below the memory write rate
    buf_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (push && !pop) |-> (buf_count < CNT_W'(`PIX_BUF_DEPTH)))
        else $error("Capture buffer overflow");

endmodule

/* source/pix_readout.sv */
`timescale 1ns/1ps

`include "pix_macros.svh"

module pix_readout (
    input  logic            clk,
    input  logic            rst_n,

    // Job port
    input  logic            rd_req,
    input  pix_pkg::block_t rd_block,
    output logic            rd_ack,

    // Host word port
    input  logic            readout_req,
    output logic            readout_ack,
    output pix_pkg::word_t  readout_data,

    // Memory client
    output logic            m1_req,
    input  logic            m1_ack,
    output pix_pkg::addr_t  m1_addr,
    input  pix_pkg::word_t  m1_rdata
);
    import pix_pkg::*;

    rd_state_t state;
    block_t    job_block;
    offset_t   rd_offset;
    logic      start;
    logic      fetch;
    logic      last_word;

    assign start     = (state == RD_IDLE) && rd_req && !rd_ack;
    // Wait for the arbiter to close the last access too
    assign fetch     = (state == RD_WAIT_REQ) && readout_req && !m1_ack;
    assign last_word = (rd_offset == offset_t'(`PIX_IMAGE_WORDS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= RD_IDLE;
            rd_ack      <= 1'b0;
            readout_ack <= 1'b0;
            m1_req      <= 1'b0;
            rd_offset   <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rd_ack && !rd_req) begin
                        rd_ack <= 1'b0;
                    end else if (start) begin
                        rd_offset <= '0;
                        state     <= RD_WAIT_REQ;
                    end
                end
                RD_WAIT_REQ: begin
                    if (fetch) begin
                        m1_req <= 1'b1;
                        state  <= RD_FETCH;
                    end
                end
                RD_FETCH: begin
                    if (m1_ack) begin
                        m1_req      <= 1'b0;
                        readout_ack <= 1'b1;
                        state       <= RD_ACK_HOST;
                    end
                end
                // Hold the word until the host lets go
                RD_ACK_HOST: begin
                    if (!readout_req) begin
                        readout_ack <= 1'b0;
                        rd_offset   <= rd_offset + 1'b1;
                        state       <= last_word ? RD_DONE : RD_WAIT_REQ;
                    end
                end
                RD_DONE: begin
                    rd_ack <= 1'b1;
                    state  <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            job_block <= rd_block;
        end
        if (fetch) begin
            m1_addr <= {job_block, rd_offset};
        end
        if ((state == RD_FETCH) && m1_ack) begin
            readout_data <= m1_rdata;
        end
    end

    data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (readout_ack ##1 readout_ack) |-> $stable(readout_data))
        else $error("readout_data changed while readout_ack was high");

endmodule

/* source/pix_cmd_ctrl.sv */
`timescale 1ns/1ps

module pix_cmd_ctrl (
    input  logic            clk,
    input  logic            rst_n,

    // Host command port
    input  pix_pkg::cmd_t   cmd,
    input  pix_pkg::block_t cmd_block,
    input  logic            cmd_req,
    output logic            cmd_ack,

    // Capture job
    output logic            cap_req,
    output pix_pkg::block_t cap_block,
    input  logic            cap_ack,

    // Readout job
    output logic            rd_req,
    output pix_pkg::block_t rd_block,
    input  logic            rd_ack
);
    import pix_pkg::*;

    ctrl_state_t state;
    block_t      job_block;
    logic        start;

    assign start     = (state == CTRL_IDLE) && cmd_req;
    // Both engines see the same latched block, only one is ever started
    assign cap_block = job_block;
    assign rd_block  = job_block;

    // ====================
    // Job sequencing
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= CTRL_IDLE;
            cmd_ack <= 1'b0;
            cap_req <= 1'b0;
            rd_req  <= 1'b0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (start) begin
                        if (cmd == CMD_CAPTURE) begin
                            cap_req <= 1'b1;
                            state   <= CTRL_RUN_CAPTURE;
                        end else begin
                            rd_req <= 1'b1;
                            state  <= CTRL_RUN_READOUT;
                        end
                    end
                end
                // Drop the request on ack, then wait for the ack to clear
                CTRL_RUN_CAPTURE: begin
                    if (cap_req && cap_ack) begin
                        cap_req <= 1'b0;
                    end else if (!cap_req && !cap_ack) begin
                        cmd_ack <= 1'b1;
                        state   <= CTRL_FINISH;
                    end
                end
                CTRL_RUN_READOUT: begin
                    if (rd_req && rd_ack) begin
                        rd_req <= 1'b0;
                    end else if (!rd_req && !rd_ack) begin
                        cmd_ack <= 1'b1;
                        state   <= CTRL_FINISH;
                    end
                end
                CTRL_FINISH: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            job_block <= cmd_block;
        end
    end

endmodule

/* source/pix_controller.sv */
`timescale 1ns/1ps

module pix_controller (
    input  logic            clk,
    input  logic            rst_n,

    // Host command port
    input  pix_pkg::cmd_t   cmd,
    input  pix_pkg::block_t cmd_block,
    input  logic            cmd_req,
    output logic            cmd_ack,

    // Host readout port
    input  logic            readout_req,
    output logic            readout_ack,
    output pix_pkg::word_t  readout_data,

    // Sensor
    input  logic            pix_fv,
    input  logic            pix_lv,
    input  pix_pkg::pix_t   pix_d
);
    import pix_pkg::*;

    // ====================
    // Job handshakes
    // ====================
    logic   cap_req;
    logic   cap_ack;
    block_t cap_block;
    logic   rd_req;
    logic   rd_ack;
    block_t rd_block;

    // ====================
    // Memory clients and port
    // ====================
    logic   m0_req;
    logic   m0_ack;
    logic   m0_we;
    addr_t  m0_addr;
    word_t  m0_wdata;
    logic   m1_req;
    logic   m1_ack;
    addr_t  m1_addr;
    word_t  m1_rdata;
    logic   mem_en;
    logic   mem_we;
    addr_t  mem_addr;
    word_t  mem_wdata;
    word_t  mem_rdata;

    pix_cmd_ctrl u_cmd_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cmd(cmd), .cmd_block(cmd_block), .cmd_req(cmd_req), .cmd_ack(cmd_ack),
        .cap_req(cap_req), .cap_block(cap_block), .cap_ack(cap_ack),
        .rd_req(rd_req), .rd_block(rd_block), .rd_ack(rd_ack)
    );

    pix_capture u_capture (
        .clk(clk), .rst_n(rst_n),
        .cap_req(cap_req), .cap_block(cap_block), .cap_ack(cap_ack),
        .pix_fv(pix_fv), .pix_lv(pix_lv), .pix_d(pix_d),
        .m0_req(m0_req), .m0_ack(m0_ack), .m0_we(m0_we),
        .m0_addr(m0_addr), .m0_wdata(m0_wdata)
    );

    pix_readout u_readout (
        .clk(clk), .rst_n(rst_n),
        .rd_req(rd_req), .rd_block(rd_block), .rd_ack(rd_ack),
        .readout_req(readout_req), .readout_ack(readout_ack), .readout_data(readout_data),
        .m1_req(m1_req), .m1_ack(m1_ack), .m1_addr(m1_addr), .m1_rdata(m1_rdata)
    );

    pix_mem_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n),
        .m0_req(m0_req), .m0_ack(m0_ack), .m0_we(m0_we),
        .m0_addr(m0_addr), .m0_wdata(m0_wdata),
        .m1_req(m1_req), .m1_ack(m1_ack), .m1_addr(m1_addr), .m1_rdata(m1_rdata),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    pix_frame_ram u_frame_ram (
        .clk(clk),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

/* verif/pix_controller_tb.sv */
`timescale 1ns/1ps

`include "pix_macros.svh"

module pix_controller_tb;
    import pix_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int WORDS        = `PIX_IMAGE_WORDS;
    localparam int FRAME_PIXELS = `PIX_IMAGE_WORDS + 2;
    // Worst case frame with nine cycle pixel spacing plus slack
    localparam int FRAME_CYCLES = 2 + FRAME_PIXELS * 10 + 20;
    localparam int MARGIN       = 4;

    typedef struct packed {
        cmd_t   cmd;
        block_t blk;
        pix_t   base;
        logic   mid_frame;
    } entry_t;

    logic   clk = 1'b0;
    logic   rst_n;
    cmd_t   cmd;
    block_t cmd_block;
    logic   cmd_req;
    logic   cmd_ack;
    logic   readout_req;
    logic   readout_ack;
    word_t  readout_data;
    logic   pix_fv;
    logic   pix_lv;
    pix_t   pix_d;

    entry_t table_q [$];
    logic   table_built = 1'b0;
    // Last pattern base written into each block
    pix_t   sb_base [`PIX_BLOCKS];
    int     pixels_sent = 0;
    int     check_count = 0;
    int     error_count = 0;

    pix_controller dut0 (
        .clk(clk), .rst_n(rst_n),
        .cmd(cmd), .cmd_block(cmd_block), .cmd_req(cmd_req), .cmd_ack(cmd_ack),
        .readout_req(readout_req), .readout_ack(readout_ack), .readout_data(readout_data),
        .pix_fv(pix_fv), .pix_lv(pix_lv), .pix_d(pix_d)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input logic ok, input string msg);
        check_count++;
        assert (ok === 1'b1) else begin
            error_count++;
            $display("error @%0t: %s", $time, msg);
        end
    endtask

    task automatic add_entry(input cmd_t c, input block_t b, input pix_t base, input logic mid);
        entry_t e;
        e.cmd       = c;
        e.blk       = b;
        e.base      = base;
        e.mid_frame = mid;
        table_q.push_back(e);
    endtask

    // ====================
    // Command table
    // ====================
    task automatic build_table();
        add_entry(CMD_CAPTURE, 3'd2, 12'h100, 1'b0);
        add_entry(CMD_READOUT, 3'd2, 12'h000, 1'b0);
        add_entry(CMD_CAPTURE, 3'd5, 12'hff8, 1'b1);
        add_entry(CMD_READOUT, 3'd5, 12'h000, 1'b0);
        add_entry(CMD_CAPTURE, 3'd0, 12'h3a0, 1'b0);
        add_entry(CMD_CAPTURE, 3'd7, 12'h7f0, 1'b1);
        add_entry(CMD_READOUT, 3'd2, 12'h000, 1'b0);
        add_entry(CMD_READOUT, 3'd0, 12'h000, 1'b0);
        add_entry(CMD_READOUT, 3'd7, 12'h000, 1'b0);
        add_entry(CMD_CAPTURE, 3'd2, 12'h055, 1'b0);
        add_entry(CMD_READOUT, 3'd2, 12'h000, 1'b0);
        add_entry(CMD_READOUT, 3'd5, 12'h000, 1'b0);
    endtask

    // Sensor frame, one pixel every six to nine cycles
    task automatic send_frame(input pix_t base);
        int gap;
        @(negedge clk);
        pix_fv      = 1'b1;
        pixels_sent = 0;
        repeat (2) @(negedge clk);
        for (int k = 0; k < FRAME_PIXELS; k++) begin
            pix_lv = 1'b1;
            pix_d  = base + pix_t'(k);
            pixels_sent++;
            @(negedge clk);
            pix_lv = 1'b0;
            gap    = 6 + ($urandom % 4);
            repeat (gap - 1) @(negedge clk);
        end
        pix_fv = 1'b0;
    endtask

    // Host side of the four-phase command handshake
    task automatic issue_command(input cmd_t c, input block_t blk);
        @(negedge clk);
        check(!cmd_ack, "cmd_ack high before the command was issued");
        cmd       = c;
        cmd_block = blk;
        cmd_req   = 1'b1;
        @(negedge clk);
        while (!cmd_ack) @(negedge clk);
        repeat ($urandom % 3) begin
            @(negedge clk);
            check(cmd_ack, "cmd_ack fell while cmd_req was still high");
        end
        cmd_req = 1'b0;
        @(negedge clk);
        check(!cmd_ack, "cmd_ack still high one cycle after cmd_req fell");
    endtask

    task automatic read_words(input block_t blk);
        word_t expected;
        word_t got;
        int    hold;
        for (int i = 0; i < WORDS; i++) begin
            repeat ($urandom % 6) @(negedge clk);
            readout_req = 1'b1;
            @(negedge clk);
            while (!readout_ack) @(negedge clk);
            // Pattern value masked to 12 bits, upper bits zero
            expected = word_t'((int'(sb_base[blk]) + i) & 32'h0fff);
            got      = readout_data;
            check(got == expected, $sformatf("block %0d word %0d: got %h, expected %h",
                blk, i, got, expected));
            check(!cmd_ack, "cmd_ack high before all words were read");
            hold = $urandom % 4;
            repeat (hold) begin
                @(negedge clk);
                check(readout_ack && (readout_data == got),
                    "readout_data or readout_ack changed while readout_req was high");
            end
            readout_req = 1'b0;
            @(negedge clk);
            while (readout_ack) @(negedge clk);
        end
    endtask

    task automatic run_capture(input block_t blk, input pix_t base, input logic mid);
        fork
            begin
                if (mid) begin
                    // Partial frame with a different pattern, must be skipped
                    send_frame(base ^ 12'h800);
                    repeat (10) @(negedge clk);
                end else begin
                    repeat (8) @(negedge clk);
                end
                send_frame(base);
            end
            begin
                if (mid) begin
                    wait (pix_fv && (pixels_sent == 5));
                end
                issue_command(CMD_CAPTURE, blk);
            end
        join
        sb_base[blk] = base;
    endtask

    task automatic run_readout(input block_t blk);
        fork
            issue_command(CMD_READOUT, blk);
            read_words(blk);
        join
    endtask

    task automatic check_idle();
        repeat (10) begin
            @(negedge clk);
            check(!cmd_ack && !readout_ack, "an ack was high with no request");
        end
        // Word request with no readout job
        readout_req = 1'b1;
        repeat (12) begin
            @(negedge clk);
            check(!readout_ack, "readout request acknowledged outside a readout job");
        end
        readout_req = 1'b0;
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin : main
        void'($urandom(32'h8dfc));
        rst_n       = 1'b0;
        cmd         = CMD_CAPTURE;
        cmd_block   = '0;
        cmd_req     = 1'b0;
        readout_req = 1'b0;
        pix_fv      = 1'b0;
        pix_lv      = 1'b0;
        pix_d       = '0;
        build_table();
        table_built = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_idle();
        foreach (table_q[n]) begin
            if (table_q[n].cmd == CMD_CAPTURE) begin
                run_capture(table_q[n].blk, table_q[n].base, table_q[n].mid_frame);
            end else begin
                run_readout(table_q[n].blk);
            end
        end
        repeat (5) @(negedge clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_built);
        #((table_q.size() * FRAME_CYCLES * MARGIN + 16) * CLK_PERIOD);
        $display("Timeout: the command table did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
source/pix_pkg.sv
source/pix_frame_ram.sv
source/pix_mem_arbiter.sv
source/pix_capture.sv
source/pix_readout.sv
source/pix_cmd_ctrl.sv
source/pix_controller.sv
verif/pix_controller_tb.sv

/* Bender.yml */
package:
  name: pix_controller

sources:
  - include_dirs:
      - include
    files:
      - source/pix_pkg.sv
      - source/pix_frame_ram.sv
      - source/pix_mem_arbiter.sv
      - source/pix_capture.sv
      - source/pix_readout.sv
      - source/pix_cmd_ctrl.sv
      - source/pix_controller.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/pix_controller_tb.sv
